// File: Makefile
TOP = processorTb

all: run

run:
	verilator --binary -j 0 -f files.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module processor

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// File: files.f
source/cpuPkg.sv
source/alu.sv
source/registerFile.sv
source/controlUnit.sv
source/branchController.sv
source/instructionMemory.sv
source/dataMemory.sv
source/processor.sv
test/processorTb.sv

// File: source/alu.sv
// Arithmetic logic unit
`timescale 1ns/1ns

module alu import cpuPkg::*; #(
	parameter int dataWidth = 32
) (
	input  logic [dataWidth-1:0] operand1,
	input  logic [dataWidth-1:0] operand2,
	input  aluOpT                opSel,
	output logic [dataWidth-1:0] result,
	output logic                 zero
);

	logic lessThan;

	// Signed compare for slt and slti.
	assign lessThan = $signed(operand1) < $signed(operand2);

	always_comb begin
		case (opSel)
			aluAdd:  result = operand1 + operand2;
			aluSub:  result = operand1 - operand2;
			aluAnd:  result = operand1 & operand2;
			aluOr:   result = operand1 | operand2;
			aluXor:  result = operand1 ^ operand2;
			aluNor:  result = ~(operand1 | operand2);
			aluSlt:  result = {{(dataWidth-1){1'b0}}, lessThan};
			aluSll:  result = operand1 << operand2[4:0];
			aluSrl:  result = operand1 >> operand2[4:0];
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

// File: source/branchController.sv
// Branch and jump decision
`timescale 1ns/1ns

module branchController import cpuPkg::*; (
	input  opcodeT      opcode,
	input  functT       funct,
	input  logic [31:0] operand1,
	input  logic [31:0] operand2,
	output logic        pcSel
);

	logic equal;

	assign equal = (operand1 == operand2);

	always_comb begin
		case (opcode)
			opBeq:      pcSel = equal;
			opBne:      pcSel = !equal;
			opJ, opJal: pcSel = 1'b1;
			opRType:    pcSel = (funct == fJr); // Return through rs.
			default:    pcSel = 1'b0;
		endcase
	end

endmodule

// File: source/controlUnit.sv
// Instruction decoder
`timescale 1ns/1ns

module controlUnit import cpuPkg::*; (
	input  opcodeT  opcode,
	input  functT   funct,
	output controlT ctrl
);

	always_comb begin
		ctrl = '0;
		case (opcode)
			opRType: begin
				ctrl.regDst     = 1'b1;
				ctrl.regWriteEn = 1'b1;
				case (funct)
					fAdd: ctrl.aluOp = aluAdd;
					fSub: ctrl.aluOp = aluSub;
					fAnd: ctrl.aluOp = aluAnd;
					fOr:  ctrl.aluOp = aluOr;
					fXor: ctrl.aluOp = aluXor;
					fNor: ctrl.aluOp = aluNor;
					fSlt: ctrl.aluOp = aluSlt;
					fSll: ctrl.aluOp = aluSll;
					fSrl: ctrl.aluOp = aluSrl;
					default: begin
						// jr and unknown codes write nothing.
						ctrl.regDst     = 1'b0;
						ctrl.regWriteEn = 1'b0;
					end
				endcase
			end
			opAddi, opSlti: begin
				ctrl.aluSrc     = 1'b1;
				ctrl.regWriteEn = 1'b1;
				ctrl.aluOp      = (opcode == opSlti) ? aluSlt : aluAdd;
			end
			opAndi, opOri, opXori: begin
				ctrl.aluSrc     = 1'b1;
				ctrl.regWriteEn = 1'b1;
				ctrl.zeroExtend = 1'b1;
				case (opcode)
					opAndi:  ctrl.aluOp = aluAnd;
					opOri:   ctrl.aluOp = aluOr;
					default: ctrl.aluOp = aluXor;
				endcase
			end
			opLw: begin
				ctrl.aluSrc     = 1'b1;
				ctrl.memToReg   = 1'b1;
				ctrl.regWriteEn = 1'b1;
				ctrl.memReadEn  = 1'b1;
				ctrl.aluOp      = aluAdd;
			end
			opSw: begin
				ctrl.aluSrc     = 1'b1;
				ctrl.memWriteEn = 1'b1;
				ctrl.aluOp      = aluAdd;
			end
			opBeq, opBne: ctrl.aluOp = aluSub;
			opJal: begin
				ctrl.regWriteEn = 1'b1;
				ctrl.link       = 1'b1;
				ctrl.aluOp      = aluAdd;
			end
			opHlt:   ctrl.halt = 1'b1;
			default: ctrl = '0; // j and unknown opcodes.
		endcase
	end

endmodule

// File: source/cpuPkg.sv
// Processor shared types
package cpuPkg;

	// Primary opcodes.
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opJal   = 6'h03,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opSlti  = 6'h0A,
		opAndi  = 6'h0C,
		opOri   = 6'h0D,
		opXori  = 6'h0E,
		opLw    = 6'h23,
		opSw    = 6'h2B,
		opHlt   = 6'h3F
	} opcodeT;

	// Function codes of register-type instructions.
	typedef enum logic [5:0] {
		fSll = 6'h00,
		fSrl = 6'h02,
		fJr  = 6'h08,
		fAdd = 6'h20,
		fSub = 6'h22,
		fAnd = 6'h24,
		fOr  = 6'h25,
		fXor = 6'h26,
		fNor = 6'h27,
		fSlt = 6'h2A
	} functT;

	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluAnd = 4'd2,
		aluOr  = 4'd3,
		aluXor = 4'd4,
		aluNor = 4'd5,
		aluSlt = 4'd6,
		aluSll = 4'd7,
		aluSrl = 4'd8
	} aluOpT;

	typedef struct packed {
		logic  regDst;     // Destination is rd.
		logic  aluSrc;     // Second operand is the immediate.
		logic  memToReg;
		logic  regWriteEn;
		logic  memWriteEn;
		logic  memReadEn;
		logic  zeroExtend;
		logic  link;       // Jump-and-link.
		logic  halt;
		aluOpT aluOp;
	} controlT;

	// Registers 0 to 5 with register 0 at index 0.
	typedef logic [5:0][31:0] regWindowT;

endpackage

// File: source/dataMemory.sv
// Data RAM
`timescale 1ns/1ns

module dataMemory #(
	parameter int dataWidth = 32,
	parameter int dataDepth = 256
) (
	input  logic                 clk,
	input  logic                 writeEn,
	input  logic                 readEn,
	input  logic [7:0]           address,
	input  logic [dataWidth-1:0] writeData,
	output logic [dataWidth-1:0] readData
);

	logic [dataWidth-1:0] mem [dataDepth];

	always_ff @(posedge clk) begin
		if (writeEn) begin
			mem[address] <= writeData;
		end
	end

	// Combinational read.
	assign readData = readEn ? mem[address] : '0;

endmodule

// File: source/instructionMemory.sv
// Test program ROM
`timescale 1ns/1ns

module instructionMemory import cpuPkg::*; #(
	parameter int romDepth = 256
) (
	input  logic [31:0] address,
	output logic [31:0] instruction
);

	function automatic logic [31:0] rWord(functT f, logic [4:0] rs, logic [4:0] rt,
		logic [4:0] rd, logic [4:0] sh);
		return {opRType, rs, rt, rd, sh, f};
	endfunction

	function automatic logic [31:0] iWord(opcodeT op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jWord(opcodeT op, logic [25:0] target);
		return {op, target};
	endfunction

	always_comb begin
		instruction = jWord(opHlt, 26'd0);
		if (address < romDepth) begin
			case (address)
				32'd0:  instruction = iWord(opAddi, 5'd0, 5'd1, 16'd5);
				32'd1:  instruction = iWord(opAddi, 5'd0, 5'd2, 16'd3);
				32'd2:  instruction = rWord(fAdd, 5'd1, 5'd2, 5'd3, 5'd0);
				32'd3:  instruction = rWord(fSub, 5'd1, 5'd2, 5'd4, 5'd0);
				32'd4:  instruction = rWord(fAnd, 5'd1, 5'd2, 5'd5, 5'd0);
				32'd5:  instruction = rWord(fOr, 5'd1, 5'd2, 5'd5, 5'd0);
				32'd6:  instruction = rWord(fXor, 5'd1, 5'd2, 5'd5, 5'd0);
				32'd7:  instruction = rWord(fNor, 5'd1, 5'd2, 5'd5, 5'd0);
				32'd8:  instruction = rWord(fSlt, 5'd5, 5'd1, 5'd5, 5'd0); // -8 < 5.
				32'd9:  instruction = rWord(fSll, 5'd0, 5'd3, 5'd3, 5'd2);
				32'd10: instruction = rWord(fSrl, 5'd0, 5'd3, 5'd3, 5'd1);
				32'd11: instruction = iWord(opAndi, 5'd3, 5'd4, 16'h00F0);
				32'd12: instruction = iWord(opOri, 5'd4, 5'd4, 16'h8000);
				32'd13: instruction = iWord(opXori, 5'd4, 5'd4, 16'hF000);
				32'd14: instruction = iWord(opSlti, 5'd4, 5'd5, 16'hFFFF);
				32'd15: instruction = iWord(opSw, 5'd0, 5'd3, 16'd4);
				32'd16: instruction = iWord(opLw, 5'd0, 5'd5, 16'd4);
				32'd17: instruction = iWord(opBeq, 5'd1, 5'd1, 16'd2);  // Skips 18.
				32'd18: instruction = iWord(opAddi, 5'd0, 5'd2, 16'h0099);
				32'd19: instruction = iWord(opBne, 5'd1, 5'd1, 16'd5);
				32'd20: instruction = jWord(opJal, 26'd24);
				32'd21: instruction = jWord(opJ, 26'd23);
				32'd22: instruction = iWord(opAddi, 5'd0, 5'd2, 16'h0077);
				32'd23: instruction = jWord(opHlt, 26'd0);
				32'd24: instruction = iWord(opAddi, 5'd1, 5'd1, 16'd1); // Subroutine.
				32'd25: instruction = rWord(fJr, 5'd31, 5'd0, 5'd0, 5'd0);
				default: instruction = jWord(opHlt, 26'd0);
			endcase
		end
	end

endmodule

// File: source/processor.sv
// Single-cycle processor top
`timescale 1ns/1ns

module processor import cpuPkg::*; (
	input  logic        clk,
	input  logic        rst,
	output logic [31:0] pc,
	output logic [31:0] cyclesConsumed,
	output logic        halted,
	output regWindowT   regWindow
);

	localparam int dataWidth = 32;
	localparam int dataDepth = 256;
	localparam int romDepth  = 256;

	logic [31:0] instruction;
	opcodeT      opcode;
	functT       funct;
	logic [4:0]  rs, rt, rd, shamt;
	logic [15:0] imm;
	logic [25:0] jumpTarget;
	controlT     ctrl;
	logic        pcSel;
	logic        isShift;
	logic [4:0]  writeReg;
	logic [31:0] readData1, readData2, extImm;
	logic [31:0] aluIn1, aluIn2, aluResult;
	logic [31:0] memReadData, writeData;
	logic [31:0] pcPlus1, branchTarget, nextPc;
	logic        regWrite, memWrite;

	// Instruction fields.
	assign opcode     = opcodeT'(instruction[31:26]);
	assign rs         = instruction[25:21];
	assign rt         = instruction[20:16];
	assign rd         = instruction[15:11];
	assign shamt      = instruction[10:6];
	assign funct      = functT'(instruction[5:0]);
	assign imm        = instruction[15:0];
	assign jumpTarget = instruction[25:0];

	instructionMemory #(.romDepth(romDepth)) imem (
		.address(pc),
		.instruction(instruction)
	);

	controlUnit cu (
		.opcode(opcode),
		.funct(funct),
		.ctrl(ctrl)
	);

	branchController bc (
		.opcode(opcode),
		.funct(funct),
		.operand1(readData1),
		.operand2(readData2),
		.pcSel(pcSel)
	);

	// Nothing retires while halted or in reset.
	assign regWrite = ctrl.regWriteEn && !halted && rst;
	assign memWrite = ctrl.memWriteEn && !halted && rst;

	assign writeReg = ctrl.link ? 5'd31 : (ctrl.regDst ? rd : rt);

	registerFile #(.dataWidth(dataWidth)) rf (
		.clk(clk),
		.rst(rst),
		.writeEn(regWrite),
		.readReg1(rs),
		.readReg2(rt),
		.writeReg(writeReg),
		.writeData(writeData),
		.readData1(readData1),
		.readData2(readData2),
		.regWindow(regWindow)
	);

	assign isShift = (ctrl.aluOp == aluSll) || (ctrl.aluOp == aluSrl);
	assign extImm  = ctrl.zeroExtend ? {16'd0, imm} : {{16{imm[15]}}, imm};

	always_comb begin
		if (ctrl.link) begin
			aluIn1 = pc; // Computes the return address.
			aluIn2 = 32'd1;
		end else if (isShift) begin
			aluIn1 = readData2;
			aluIn2 = {27'd0, shamt};
		end else begin
			aluIn1 = readData1;
			aluIn2 = ctrl.aluSrc ? extImm : readData2;
		end
	end

	alu #(.dataWidth(dataWidth)) ex (
		.operand1(aluIn1),
		.operand2(aluIn2),
		.opSel(ctrl.aluOp),
		.result(aluResult),
		.zero()
	);

	dataMemory #(.dataWidth(dataWidth), .dataDepth(dataDepth)) dmem (
		.clk(clk),
		.writeEn(memWrite),
		.readEn(ctrl.memReadEn),
		.address(aluResult[7:0]),
		.writeData(readData2),
		.readData(memReadData)
	);

	assign writeData = ctrl.memToReg ? memReadData : aluResult;

	assign pcPlus1      = pc + 32'd1;
	assign branchTarget = pc + {22'd0, imm[9:0]};

	always_comb begin
		nextPc = pcPlus1;
		if (pcSel) begin
			case (opcode)
				opJ, opJal: nextPc = {6'd0, jumpTarget};
				opRType:    nextPc = readData1; // Only jr selects here.
				default:    nextPc = branchTarget;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pc             <= '0;
			cyclesConsumed <= '0;
			halted         <= 1'b0;
		end else if (!halted) begin
			cyclesConsumed <= cyclesConsumed + 32'd1;
			if (ctrl.halt) begin
				halted <= 1'b1; // PC stays on hlt.
			end else begin
				pc <= nextPc;
			end
		end
	end

endmodule

// File: source/registerFile.sv
// General purpose register file
`timescale 1ns/1ns

module registerFile import cpuPkg::*; #(
	parameter int dataWidth = 32
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 writeEn,
	input  logic [4:0]           readReg1,
	input  logic [4:0]           readReg2,
	input  logic [4:0]           writeReg,
	input  logic [dataWidth-1:0] writeData,
	output logic [dataWidth-1:0] readData1,
	output logic [dataWidth-1:0] readData2,
	output regWindowT            regWindow
);

	logic [dataWidth-1:0] regs [32];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeReg != 5'd0) begin
			regs[writeReg] <= writeData;
		end
	end

	assign readData1 = (readReg1 == 5'd0) ? '0 : regs[readReg1];
	assign readData2 = (readReg2 == 5'd0) ? '0 : regs[readReg2];

	always_comb begin
		for (int i = 0; i < 6; i++) begin
			regWindow[i] = regs[i];
		end
	end

endmodule

// File: test/processorTb.sv
// Processor testbench
`timescale 1ns/1ns

module processorTb import cpuPkg::*; ();

	// Expected outputs once the given number of cycles has retired.
	typedef struct packed {
		int          cycle;
		logic [31:0] pc;
		logic [31:0] consumed;
		logic        halted;
		regWindowT   window;
	} rowT;

	logic        clk;
	logic        rst;
	logic [31:0] pc;
	logic [31:0] cyclesConsumed;
	logic        halted;
	regWindowT   regWindow;

	rowT rows[$];
	int  cycle = 0;
	int  timeoutLimit = 0;
	int  errors = 0;
	int  checks = 0;

	processor UUT (
		.clk(clk),
		.rst(rst),
		.pc(pc),
		.cyclesConsumed(cyclesConsumed),
		.halted(halted),
		.regWindow(regWindow)
	);

	always #50 clk = ~clk;

	// Clock edges since reset release.
	always @(posedge clk) begin
		if (!rst) begin
			cycle <= 0;
		end else begin
			cycle <= cycle + 1;
		end
	end

	always @(posedge clk) begin
		if (timeoutLimit > 0 && cycle >= timeoutLimit) begin
			$display("Timeout: the run did not finish within %0d cycles.", timeoutLimit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function automatic void addRow(int cyc, logic [31:0] pcVal, logic [31:0] consumed,
		logic haltedVal, logic [31:0] r1, logic [31:0] r2, logic [31:0] r3,
		logic [31:0] r4, logic [31:0] r5);
		rowT row;
		row.cycle    = cyc;
		row.pc       = pcVal;
		row.consumed = consumed;
		row.halted   = haltedVal;
		row.window   = {r5, r4, r3, r2, r1, 32'd0}; // Register 0 sits at index 0.
		rows.push_back(row);
	endfunction

	// Expected state after each retired instruction of the ROM program.
	function automatic void buildTable();
		addRow(0,  32'd0,  32'd0,  1'b0, 32'h0, 32'h0, 32'h0,  32'h0,    32'h0);
		addRow(1,  32'd1,  32'd1,  1'b0, 32'h5, 32'h0, 32'h0,  32'h0,    32'h0);
		addRow(2,  32'd2,  32'd2,  1'b0, 32'h5, 32'h3, 32'h0,  32'h0,    32'h0);
		addRow(3,  32'd3,  32'd3,  1'b0, 32'h5, 32'h3, 32'h8,  32'h0,    32'h0);
		addRow(4,  32'd4,  32'd4,  1'b0, 32'h5, 32'h3, 32'h8,  32'h2,    32'h0);
		addRow(5,  32'd5,  32'd5,  1'b0, 32'h5, 32'h3, 32'h8,  32'h2,    32'h1);
		addRow(6,  32'd6,  32'd6,  1'b0, 32'h5, 32'h3, 32'h8,  32'h2,    32'h7);
		addRow(7,  32'd7,  32'd7,  1'b0, 32'h5, 32'h3, 32'h8,  32'h2,    32'h6);
		addRow(8,  32'd8,  32'd8,  1'b0, 32'h5, 32'h3, 32'h8,  32'h2,    32'hFFFFFFF8);
		addRow(9,  32'd9,  32'd9,  1'b0, 32'h5, 32'h3, 32'h8,  32'h2,    32'h1);
		addRow(10, 32'd10, 32'd10, 1'b0, 32'h5, 32'h3, 32'h20, 32'h2,    32'h1);
		addRow(11, 32'd11, 32'd11, 1'b0, 32'h5, 32'h3, 32'h10, 32'h2,    32'h1);
		addRow(12, 32'd12, 32'd12, 1'b0, 32'h5, 32'h3, 32'h10, 32'h10,   32'h1);
		addRow(13, 32'd13, 32'd13, 1'b0, 32'h5, 32'h3, 32'h10, 32'h8010, 32'h1);
		addRow(14, 32'd14, 32'd14, 1'b0, 32'h5, 32'h3, 32'h10, 32'h7010, 32'h1);
		addRow(15, 32'd15, 32'd15, 1'b0, 32'h5, 32'h3, 32'h10, 32'h7010, 32'h0);
		addRow(16, 32'd16, 32'd16, 1'b0, 32'h5, 32'h3, 32'h10, 32'h7010, 32'h0);
		addRow(17, 32'd17, 32'd17, 1'b0, 32'h5, 32'h3, 32'h10, 32'h7010, 32'h10);
		addRow(18, 32'd19, 32'd18, 1'b0, 32'h5, 32'h3, 32'h10, 32'h7010, 32'h10);
		addRow(19, 32'd20, 32'd19, 1'b0, 32'h5, 32'h3, 32'h10, 32'h7010, 32'h10);
		addRow(20, 32'd24, 32'd20, 1'b0, 32'h5, 32'h3, 32'h10, 32'h7010, 32'h10);
		addRow(21, 32'd25, 32'd21, 1'b0, 32'h6, 32'h3, 32'h10, 32'h7010, 32'h10);
		addRow(22, 32'd21, 32'd22, 1'b0, 32'h6, 32'h3, 32'h10, 32'h7010, 32'h10);
		addRow(23, 32'd23, 32'd23, 1'b0, 32'h6, 32'h3, 32'h10, 32'h7010, 32'h10);
		// Halted from here on so the count stays at 24.
		addRow(24, 32'd23, 32'd24, 1'b1, 32'h6, 32'h3, 32'h10, 32'h7010, 32'h10);
		addRow(34, 32'd23, 32'd24, 1'b1, 32'h6, 32'h3, 32'h10, 32'h7010, 32'h10);
	endfunction

	task automatic checkWord(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s at cycle %0d: expected %h, got %h", name, cycle, expected,
				actual);
		end
	endtask

	task automatic checkWindow(input regWindowT expected, input regWindowT actual);
		for (int i = 0; i < 6; i++) begin
			checks++;
			if (actual[i] !== expected[i]) begin
				errors++;
				$display("[FAIL] regWindow[%0d] at cycle %0d: expected %h, got %h", i, cycle,
					expected[i], actual[i]);
			end
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s at cycle %0d: expected %h, got %h", name, cycle, expected,
				actual);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		buildTable();
		timeoutLimit = rows[rows.size() - 1].cycle + 20;
		repeat (3) @(posedge clk);
		rst <= 1'b1;
		foreach (rows[i]) begin
			// Outputs are settled on the falling edge.
			do begin
				@(negedge clk);
			end while (cycle < rows[i].cycle);
			checkWord("pc", rows[i].pc, pc);
			checkWord("cyclesConsumed", rows[i].consumed, cyclesConsumed);
			checkWindow(rows[i].window, regWindow);
			checkBit("halted", rows[i].halted, halted);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
